// ==== src/fp_addsub_defs.svh ====
`ifndef FP_ADDSUB_DEFS_SVH
`define FP_ADDSUB_DEFS_SVH

// single precision field widths
`define FP_EXP_W   8
`define FP_FRAC_W  23

// exponent bias, kept next to the field widths
`define FP_BIAS    127

// all-ones exponent, overflow limit in the round stage
`define FP_EXP_MAX 255

// extended mantissa used between stages
// [27] carry, [26] hidden, [25:3] fraction, [2] guard, [1] round, [0] sticky
`define FP_EXT_W   28

`endif

// ==== src/fp_pkg.sv ====
`default_nettype none

`include "fp_addsub_defs.svh"

package fp_pkg;

  // operation code from the top level
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } fp_op_e;

  // control sequence, one state per cycle
  typedef enum logic [2:0] {
    S_IDLE  = 3'd0,
    S_ALIGN = 3'd1,  // align result registered, mantissa add pending
    S_ADD   = 3'd2,  // raw sum registered
    S_NORM  = 3'd3,  // normalized value registered
    S_ROUND = 3'd4   // result registered, done pulse out
  } ctrl_state_e;

  // ieee-754 single precision word
  typedef struct packed {
    logic                  sign;
    logic [`FP_EXP_W-1:0]  exp;
    logic [`FP_FRAC_W-1:0] frac;
  } fp32_t;

endpackage

`default_nettype wire

// ==== src/fp_stage_if.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fp_addsub_defs.svh"

// one intermediate value passed from a stage register to the next stage
interface fp_stage_if;

  logic                         sign;    // result sign so far
  logic signed [`FP_EXP_W+1:0]  exp;     // two bits of headroom for norm over/underflow
  logic [`FP_EXT_W-1:0]         mant;    // carry, hidden, fraction, g, r, s
  logic                         is_sub;  // effective subtraction

  // producing stage owns the register
  modport src (
    output sign,
    output exp,
    output mant,
    output is_sub
  );

  modport dst (
    input sign,
    input exp,
    input mant,
    input is_sub
  );

endinterface

`default_nettype wire

// ==== src/fp_add_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_add_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic align_en,
  output logic add_en,
  output logic norm_en,
  output logic round_en,
  output logic done,
  output logic busy
);

  fp_pkg::ctrl_state_e state;
  fp_pkg::ctrl_state_e state_nxt;

  // fixed walk through the stages, no data dependence
  always_comb begin
    state_nxt = state;
    case (state)
      fp_pkg::S_IDLE: begin
        if (align_en) begin  // leave idle on the align load edge
          state_nxt = fp_pkg::S_ALIGN;
        end
      end
      fp_pkg::S_ALIGN: state_nxt = fp_pkg::S_ADD;
      fp_pkg::S_ADD:   state_nxt = fp_pkg::S_NORM;
      fp_pkg::S_NORM:  state_nxt = fp_pkg::S_ROUND;
      fp_pkg::S_ROUND: state_nxt = fp_pkg::S_IDLE;
      default:         state_nxt = fp_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= fp_pkg::S_IDLE;
      align_en <= 1'b0;
      done     <= 1'b0;
    end else begin
      state <= state_nxt;
      // start only counts in idle and not on the pending align edge
      // operands get captured one cycle after the start edge
      align_en <= start && (state == fp_pkg::S_IDLE) && !align_en;
      done     <= (state == fp_pkg::S_NORM);  // lines up with the result load
    end
  end

  // one-hot stage loads, each a single cycle
  assign add_en   = (state == fp_pkg::S_ALIGN);
  assign norm_en  = (state == fp_pkg::S_ADD);
  assign round_en = (state == fp_pkg::S_NORM);

  assign busy = (state != fp_pkg::S_IDLE);

endmodule

`default_nettype wire

// ==== src/fp_align.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fp_addsub_defs.svh"

module fp_align (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 align_en,
  input  fp_pkg::fp32_t        a,
  input  fp_pkg::fp32_t        b,
  input  fp_pkg::fp_op_e       op,
  fp_stage_if.src              aligned,
  output logic [`FP_EXT_W-1:0] small_mant
);

  logic                     sign_b;     // b sign with the op folded in
  logic                     a_big;      // a has the larger magnitude
  logic                     sign_l;
  logic                     sign_s;
  logic [`FP_EXP_W-1:0]     exp_a_eff;
  logic [`FP_EXP_W-1:0]     exp_b_eff;
  logic [`FP_EXP_W-1:0]     exp_l;
  logic [`FP_EXP_W-1:0]     exp_s;
  logic [`FP_EXP_W-1:0]     exp_diff;
  logic [`FP_EXP_W-1:0]     sh_amt;
  logic [`FP_EXT_W-1:0]     mant_a;
  logic [`FP_EXT_W-1:0]     mant_b;
  logic [`FP_EXT_W-1:0]     mant_l;
  logic [`FP_EXT_W-1:0]     mant_s;
  logic [2*`FP_EXT_W-1:0]   shift_word;  // upper half kept, lower half lost
  logic [`FP_EXT_W-1:0]     small_w;

  assign sign_b = b.sign ^ (op == fp_pkg::OP_SUB);  // a - b as a + (-b)

  // subnormal: hidden bit 0 and effective exponent 1
  assign exp_a_eff = (a.exp == '0) ? `FP_EXP_W'(1) : a.exp;
  assign exp_b_eff = (b.exp == '0) ? `FP_EXP_W'(1) : b.exp;
  assign mant_a    = {1'b0, (a.exp != '0), a.frac, 3'b000};
  assign mant_b    = {1'b0, (b.exp != '0), b.frac, 3'b000};

  // magnitude order, exponent first then fraction
  assign a_big  = {a.exp, a.frac} >= {b.exp, b.frac};
  assign sign_l = a_big ? a.sign : sign_b;
  assign sign_s = a_big ? sign_b : a.sign;
  assign exp_l  = a_big ? exp_a_eff : exp_b_eff;
  assign exp_s  = a_big ? exp_b_eff : exp_a_eff;
  assign mant_l = a_big ? mant_a : mant_b;
  assign mant_s = a_big ? mant_b : mant_a;

  assign exp_diff = exp_l - exp_s;  // never negative after the swap
  // past FP_EXT_W the whole mantissa is sticky anyway
  assign sh_amt   = (exp_diff > `FP_EXP_W'(`FP_EXT_W)) ? `FP_EXP_W'(`FP_EXT_W) : exp_diff;

  assign shift_word = {mant_s, {`FP_EXT_W{1'b0}}} >> sh_amt;
  // everything below the sticky position ors into sticky
  assign small_w    = {shift_word[2*`FP_EXT_W-1:`FP_EXT_W+1],
                       shift_word[`FP_EXT_W] | (|shift_word[`FP_EXT_W-1:0])};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aligned.sign   <= 1'b0;
      aligned.exp    <= '0;
      aligned.mant   <= '0;
      aligned.is_sub <= 1'b0;
      small_mant     <= '0;
    end else if (align_en) begin
      aligned.sign   <= sign_l;           // larger operand decides the sign
      aligned.exp    <= {2'b00, exp_l};
      aligned.mant   <= mant_l;
      aligned.is_sub <= sign_l ^ sign_s;  // effective op from the signs
      small_mant     <= small_w;
    end
  end

endmodule

`default_nettype wire

// ==== src/fp_mant_add.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fp_addsub_defs.svh"

module fp_mant_add (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 add_en,
  fp_stage_if.dst              aligned,
  input  logic [`FP_EXT_W-1:0] small_mant,
  fp_stage_if.src              sum
);

  logic [`FP_EXT_W-1:0] raw;   // carry bit at the top absorbs add overflow
  logic                 zero;  // exact cancellation

  // larger minus smaller, so the difference never wraps
  assign raw  = aligned.is_sub ? (aligned.mant - small_mant)
                               : (aligned.mant + small_mant);
  assign zero = aligned.is_sub && (raw == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum.sign   <= 1'b0;
      sum.exp    <= '0;
      sum.mant   <= '0;
      sum.is_sub <= 1'b0;
    end else if (add_en) begin
      sum.sign   <= zero ? 1'b0 : aligned.sign;  // x - x is +0 in nearest-even
      sum.exp    <= aligned.exp;
      sum.mant   <= raw;
      sum.is_sub <= aligned.is_sub;
    end
  end

endmodule

`default_nettype wire

// ==== src/fp_normalize.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fp_addsub_defs.svh"

module fp_normalize (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    norm_en,
  fp_stage_if.dst sum,
  fp_stage_if.src norm
);

  logic [4:0]                  lz;       // leading zeros below the carry bit
  logic signed [`FP_EXP_W+1:0] lz_ext;
  logic signed [`FP_EXP_W+1:0] exp_lim;  // shift that reaches exponent 1
  logic signed [`FP_EXP_W+1:0] sh;
  logic [4:0]                  sh_amt;
  logic                        carry;
  logic [`FP_EXT_W-1:0]        mant_n;
  logic signed [`FP_EXP_W+1:0] exp_n;

  // priority search, highest set bit wins
  always_comb begin
    lz = 5'(`FP_EXT_W - 1);  // all zero below the carry
    for (int i = 0; i < `FP_EXT_W - 1; i++) begin
      if (sum.mant[i]) begin
        lz = 5'(`FP_EXT_W - 2 - i);
      end
    end
  end

  assign lz_ext  = {5'b00000, lz};
  assign exp_lim = sum.exp - 1'b1;
  assign sh      = (lz_ext > exp_lim) ? exp_lim : lz_ext;  // stop at the subnormal floor
  assign sh_amt  = sh[4:0];  // at most FP_EXT_W-1
  assign carry   = !sum.is_sub && sum.mant[`FP_EXT_W-1];  // only an add can carry out

  always_comb begin
    if (carry) begin
      // one step right, the dropped bit goes into sticky
      mant_n = {1'b0, sum.mant[`FP_EXT_W-1:2], |sum.mant[1:0]};
      exp_n  = sum.exp + 1'b1;
    end else if (sum.mant == '0) begin
      mant_n = '0;
      exp_n  = '0;
    end else begin
      mant_n = sum.mant << sh_amt;
      exp_n  = sum.exp - sh;  // hidden bit may stay 0 here, subnormal
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      norm.sign   <= 1'b0;
      norm.exp    <= '0;
      norm.mant   <= '0;
      norm.is_sub <= 1'b0;
    end else if (norm_en) begin
      norm.sign   <= sum.sign;
      norm.exp    <= exp_n;
      norm.mant   <= mant_n;
      norm.is_sub <= sum.is_sub;
    end
  end

endmodule

`default_nettype wire

// ==== src/fp_round.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fp_addsub_defs.svh"

module fp_round (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          round_en,
  fp_stage_if.dst       norm,
  output fp_pkg::fp32_t result
);

  logic [`FP_FRAC_W:0]         keep;     // hidden plus fraction
  logic                        guard;
  logic                        rnd;
  logic                        sticky;
  logic                        inc;
  logic [`FP_FRAC_W+1:0]       rounded;  // one extra bit for the mantissa carry
  logic                        m_carry;
  logic                        hidden;
  logic signed [`FP_EXP_W+1:0] exp_r;
  fp_pkg::fp32_t               packed_w;

  assign keep   = norm.mant[`FP_EXT_W-2:3];
  assign guard  = norm.mant[2];
  assign rnd    = norm.mant[1];
  assign sticky = norm.mant[0];

  // ties go to the even neighbour
  assign inc     = guard && (rnd || sticky || keep[0]);
  assign rounded = {1'b0, keep} + {{(`FP_FRAC_W+1){1'b0}}, inc};
  assign m_carry = rounded[`FP_FRAC_W+1];               // 1.111.. rolled over to 10.000..
  assign exp_r   = norm.exp + m_carry;
  assign hidden  = m_carry || rounded[`FP_FRAC_W];      // subnormal can round up to exp 1

  always_comb begin
    packed_w.sign = norm.sign;
    if (hidden && (exp_r >= `FP_EXP_MAX)) begin
      packed_w.exp  = '1;  // signed infinity
      packed_w.frac = '0;
    end else if (hidden) begin
      packed_w.exp  = exp_r[`FP_EXP_W-1:0];
      packed_w.frac = rounded[`FP_FRAC_W-1:0];  // all zero after a mantissa carry
    end else begin
      packed_w.exp  = '0;  // subnormal or zero
      packed_w.frac = rounded[`FP_FRAC_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else if (round_en) begin
      result <= packed_w;  // held until the next operation completes
    end
  end

endmodule

`default_nettype wire

// ==== src/fp_addsub_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fp_addsub_defs.svh"

module fp_addsub_top (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  input  fp_pkg::fp_op_e op,
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  output logic [31:0]    result,
  output logic           done,
  output logic           busy
);

  logic                 align_en;
  logic                 add_en;
  logic                 norm_en;
  logic                 round_en;
  logic [`FP_EXT_W-1:0] small_mant;  // shifted smaller operand, beside align_bus
  fp_pkg::fp32_t        result_w;

  fp_stage_if align_bus ();
  fp_stage_if sum_bus ();
  fp_stage_if norm_bus ();

  fp_add_ctrl ctrl0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .align_en (align_en),
    .add_en   (add_en),
    .norm_en  (norm_en),
    .round_en (round_en),
    .done     (done),
    .busy     (busy)
  );

  fp_align align0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .align_en   (align_en),
    .a          (fp_pkg::fp32_t'(a)),
    .b          (fp_pkg::fp32_t'(b)),
    .op         (op),
    .aligned    (align_bus),
    .small_mant (small_mant)
  );

  fp_mant_add add0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .add_en     (add_en),
    .aligned    (align_bus),
    .small_mant (small_mant),
    .sum        (sum_bus)
  );

  fp_normalize norm0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .norm_en (norm_en),
    .sum     (sum_bus),
    .norm    (norm_bus)
  );

  fp_round round0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .round_en (round_en),
    .norm     (norm_bus),
    .result   (result_w)
  );

  assign result = result_w;

endmodule

`default_nettype wire

// ==== tb/tb_fp_addsub.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fp_addsub;

  localparam int RESET_CYCLES   = 8;
  localparam int CYCLES_PER_VEC = 12;  // drive, start edge, 4 stages, idle check, gap
  localparam int GHOST_AT       = 5;   // this run gets a stray start while busy

  logic           clk;
  logic           rst_n;
  logic           start;
  fp_pkg::fp_op_e op;
  logic [31:0]    a;
  logic [31:0]    b;
  logic [31:0]    result;
  logic           done;
  logic           busy;

  logic           vec_op[$];
  logic [31:0]    vec_a[$];
  logic [31:0]    vec_b[$];
  logic [31:0]    vec_res[$];  // expected packed result
  int             n_err;
  int             seed;
  logic           loaded;      // vector count known, watchdog may start

  fp_addsub_top dut0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .op     (op),
    .a      (a),
    .b      (b),
    .result (result),
    .done   (done),
    .busy   (busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run;
    $display("Checks failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_result(input string name, input fp_pkg::fp32_t got,
                              input fp_pkg::fp32_t want);
    if (got !== want) begin
      n_err++;
      $display("ERROR %s got %h expected %h", name, got, want);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      n_err++;
      $display("ERROR %s got %h expected %h", name, got, want);
      fail_run();
    end
  endtask

  task automatic load_vectors;
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_r;
    fd = $fopen("tb/fp_addsub_vectors.txt", "r");
    if (fd == 0) begin
      $display("the vector file tb/fp_addsub_vectors.txt could not be opened");
      fail_run();
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line[0] != "#") begin  // skip blank and comment lines
          cnt = $sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_r);
          if (cnt == 4) begin
            vec_op.push_back(f_op[0]);
            vec_a.push_back(f_a);
            vec_b.push_back(f_b);
            vec_res.push_back(f_r);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // one operation from start to the idle cycle after done
  // ghost >= 0 pulses start again with that vector in the last busy cycle
  task automatic run_vector(input int idx, input int ghost);
    int k;
    @(posedge clk);
    start <= 1'b1;
    op    <= fp_pkg::fp_op_e'(vec_op[idx]);
    a     <= vec_a[idx];
    b     <= vec_b[idx];
    @(posedge clk);                 // start edge, operands held for the align load
    start <= 1'b0;
    @(negedge clk);
    check_flag("busy", busy, 1'b0);  // still idle, align load pending
    check_flag("done", done, 1'b0);
    k = 0;
    while (!done) begin
      @(posedge clk);
      if (ghost >= 0 && k == 3) begin
        start <= 1'b1;              // seen by the fsm in S_ROUND
        op    <= fp_pkg::fp_op_e'(vec_op[ghost]);
        a     <= vec_a[ghost];
        b     <= vec_b[ghost];
      end else begin
        start <= 1'b0;
      end
      k++;
      @(negedge clk);
      check_flag("busy", busy, 1'b1);
      check_flag("done", done, k == 4);  // early or late done both fail here
    end
    check_result("result", result, vec_res[idx]);
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_flag("done", done, 1'b0);  // single cycle pulse
    check_flag("busy", busy, 1'b0);
    check_result("result", result, vec_res[idx]);  // held after done
    if (ghost >= 0) begin
      // a stray start that got through would have left idle by now
      @(posedge clk);
      @(negedge clk);
      check_flag("busy", busy, 1'b0);
      check_flag("done", done, 1'b0);
      check_result("result", result, vec_res[idx]);
    end
  endtask

  initial begin
    int gap;
    rst_n  = 1'b0;
    start  = 1'b0;
    op     = fp_pkg::OP_ADD;
    a      = 32'h0;
    b      = 32'h0;
    n_err  = 0;
    seed   = 89861;
    loaded = 1'b0;
    load_vectors();
    if (vec_a.size() == 0) begin
      $display("the vector file holds no vectors");
      fail_run();
    end
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("done", done, 1'b0);
    check_flag("busy", busy, 1'b0);
    check_result("result", result, 32'h0);
    for (int i = 0; i < vec_a.size(); i++) begin
      run_vector(i, (i == GHOST_AT && i + 1 < vec_a.size()) ? i + 1 : -1);
      gap = $random(seed) & 3;   // 0 to 3 idle cycles
      repeat (gap) @(posedge clk);
    end
    if (n_err == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      fail_run();
    end
  end

  // watchdog sized from the vector count
  initial begin
    wait (loaded);
    repeat (vec_a.size() * CYCLES_PER_VEC + RESET_CYCLES + 20) @(posedge clk);
    $display("timeout: the operations did not complete in the expected time");
    fail_run();
  end

endmodule

`default_nettype wire

// ==== tb/fp_addsub_vectors.txt ====
# columns: op (0 add, 1 sub), a, b, expected result, all hex
# ieee-754 single precision, nearest-even, no nan or infinity inputs
0 3f800000 3f800000 40000000
0 3f800000 40000000 40400000
0 3fc00000 40100000 40700000
0 3dcccccd 3e4ccccd 3e99999a
0 c0000000 c0400000 c0a00000
0 40a00000 c0400000 40000000
0 bf800000 3e800000 bf400000
1 40400000 3f800000 40000000
1 3f800000 40400000 c0000000
1 c0000000 c0a00000 40400000
1 3f800000 bf800000 40000000
1 3f800000 3f800001 b4000000
1 3fc00000 3fbfffff 34000000
1 40000000 3fffffff 34000000
1 41200001 41200000 35800000
1 3f800000 33000000 3f800000
1 3f800000 33400000 3f7fffff
0 3f800000 2b800000 3f800000
1 3f800000 2b800000 3f800000
1 3f800001 2b800000 3f800001
0 2b800000 c0000000 c0000000
0 3f800000 33800000 3f800000
0 3f800001 33800000 3f800002
0 3f800000 33800080 3f800001
0 3fffffff 34000000 40000000
0 3fffffff 33800000 40000000
0 3fffffff 3fffffff 407fffff
0 3f800001 3f800000 40000000
0 3f800003 3f800000 40000002
1 40490fdb 40490fdb 00000000
0 c0490fdb 40490fdb 00000000
1 00000000 00000000 00000000
0 80000000 80000000 80000000
0 00400000 00400000 00800000
0 007fffff 00000001 00800000
0 00000003 00000005 00000008
1 00800001 00800000 00000001
1 00c00000 00800000 00400000
1 01000000 00ffffff 00000001
0 7f7fffff 7f7fffff 7f800000
0 ff7fffff ff7fffff ff800000
1 7f7fffff ff7fffff 7f800000
0 7f7fffff 73000000 7f800000

// ==== all.f ====
+incdir+src
src/fp_pkg.sv
src/fp_stage_if.sv
src/fp_add_ctrl.sv
src/fp_align.sv
src/fp_mant_add.sv
src/fp_normalize.sv
src/fp_round.sv
src/fp_addsub_top.sv
tb/tb_fp_addsub.sv

// ==== Makefile ====
TOP  := tb_fp_addsub
SRCS := $(wildcard src/*.sv src/*.svh tb/*.sv)

obj_dir/V$(TOP): all.f $(SRCS)
	verilator --binary --timing -Wno-fatal -j 0 -f all.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
